//--- sources.f
+incdir+dv
source/bridge_pkg.sv
source/bus_sequencer.sv
source/slot_select.sv
source/memory_mapper.sv
source/config_regs.sv
source/read_data_mux.sv
source/slot_bridge_top.sv
dv/tb_slot_bridge.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_slot_bridge
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS    := $(filter %.sv %.v,$(shell cat $(FILELIST)))
HDRS    := $(wildcard dv/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf $(BUILD_DIR)

//--- dv/bridge_model.svh
`ifndef BRIDGE_MODEL_SVH
`define BRIDGE_MODEL_SVH

// mirror of the bridge registers
logic [7:0] m_ppi_a;
logic [7:0] m_exp_slot3;
logic [7:0] m_config0;
logic [7:0] m_config1;
logic [7:0] m_pages [4];

task automatic model_reset();
    m_ppi_a     = 8'h00;
    m_exp_slot3 = 8'h00;
    m_config0   = 8'h00;
    m_config1   = CONFIG1_RESET;
    m_pages[0]  = 8'd3;
    m_pages[1]  = 8'd2;
    m_pages[2]  = 8'd1;
    m_pages[3]  = 8'd0;
endtask

// primary slot of the page that addr falls in
function automatic logic [1:0] model_pri_slot(input logic [15:0] addr);
    return m_ppi_a[addr[15:14] * 2 +: 2];
endfunction

function automatic logic model_mapper_hit(input logic [15:0] addr);
    logic [1:0] mslot;
    logic [1:0] sub;
    mslot = m_config1[5:4];
    sub   = m_exp_slot3[addr[15:14] * 2 +: 2];
    if (!m_config1[0] || model_pri_slot(addr) != mslot)
        return 1'b0;
    if (mslot != 2'd0)
        return 1'b1;
    // slot 0 mapper lives in subslot 3, minus the FFFFh register
    return (sub == 2'd3) && (addr != 16'hFFFF);
endfunction

function automatic logic [21:0] model_mapper_addr(input logic [15:0] addr);
    return {m_pages[addr[15:14]], addr[13:0]};
endfunction

// accesses that the bridge answers itself
function automatic logic model_internal(input logic is_io, input logic is_wr,
                                        input logic [15:0] addr);
    if (is_io)
        return !is_wr && (addr[7:0] == PPI_A_PORT);
    return (model_pri_slot(addr) == 2'd0) || model_mapper_hit(addr);
endfunction

function automatic logic [7:0] model_read(input logic is_io, input logic [15:0] addr,
                                          input logic [7:0] ext, input logic [7:0] mem);
    logic [7:0] port;
    port = addr[7:0];
    if (!is_io) begin
        if (model_mapper_hit(addr))
            return mem;
        if (model_pri_slot(addr) == 2'd0 && addr == 16'hFFFF)
            return ~m_exp_slot3;
        if (model_pri_slot(addr) == 2'd0)
            return 8'hFF;
        return ext;
    end
    if (port == PPI_A_PORT)
        return m_ppi_a;
    if (port[7:4] == 4'h4) begin
        if (port == CONFIG0_PORT)
            return m_config0;
        if (port == CONFIG1_PORT)
            return m_config1;
        return 8'hFF;
    end
    return ext;
endfunction

task automatic model_write(input logic is_io, input logic [15:0] addr, input logic [7:0] data);
    if (is_io) begin
        if (addr[7:0] == PPI_A_PORT)
            m_ppi_a = data;
        else if (addr[7:0] == CONFIG0_PORT)
            m_config0 = ~data;
        else if (addr[7:0] == CONFIG1_PORT && m_config0 == CONFIG_UNLOCK)
            m_config1 = data;
        else if (addr[7:2] == 6'h3F)
            m_pages[addr[1:0]] = data;
    end else if (model_pri_slot(addr) == 2'd0 && addr == 16'hFFFF) begin
        m_exp_slot3 = data;
    end
endtask

`endif

//--- dv/tb_slot_bridge.sv
`default_nettype none

module tb_slot_bridge
    import bridge_pkg::*;
();

    localparam int HOLD_CYCLES = 5;
    localparam int WAIT_LIMIT  = 20;

    logic       clk_108m;
    logic       bus_reset_n;
    logic       update_addr;
    cpu_bus_t   bus_in;
    logic [7:0] ext_data;
    logic [7:0] mem_rdata;
    ext_bus_t   ext_bus;
    mem_req_t   mem_req;
    logic [7:0] cpu_din;

    int          checks;
    int          value_errors;
    int          timeouts;
    logic [31:0] lfsr_state;

    `include "bridge_model.svh"

    slot_bridge_top u_dut (
        .clk_108m    (clk_108m),
        .bus_reset_n (bus_reset_n),
        .bus_in      (bus_in),
        .update_addr (update_addr),
        .ext_data    (ext_data),
        .mem_rdata   (mem_rdata),
        .ext_bus     (ext_bus),
        .mem_req     (mem_req),
        .cpu_din     (cpu_din)
    );

    initial begin
        clk_108m = 1'b0;
        forever #50 clk_108m = ~clk_108m;
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    task automatic check_equal(input logic [31:0] got, input logic [31:0] expected,
                               input string what);
        checks++;
        if (got !== expected) begin
            value_errors++;
            $display("CHECK FAILED at time %0t: %s, got %0h, expected %0h",
                     $time, what, got, expected);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk_108m);
        #10;
    endtask

    // ----------------------------------------------------------------------
    // one CPU bus cycle: address phase, strobe held, release
    // ----------------------------------------------------------------------
    task automatic run_cycle(input logic is_io, input logic is_wr,
                             input logic [15:0] addr, input logic [7:0] data);
        logic internal;
        logic hit;
        bus_in.addr   = addr;
        bus_in.dout   = data;
        bus_in.mreq_n = is_io;
        bus_in.iorq_n = !is_io;
        ext_data      = 8'(rand_bits(8));
        mem_rdata     = 8'(rand_bits(8));
        next_cycle();
        bus_in.rd_n = is_wr;
        bus_in.wr_n = !is_wr;
        internal = model_internal(is_io, is_wr, addr);
        hit      = !is_io && model_mapper_hit(addr);
        for (int i = 0; i < HOLD_CYCLES; i++) begin
            @(negedge clk_108m);
            if (!is_wr)
                check_equal(cpu_din, model_read(is_io, addr, ext_data, mem_rdata), "cpu_din");
            check_equal(mem_req.rd, hit && !is_wr, "mem_req.rd");
            check_equal(mem_req.wr, hit && is_wr, "mem_req.wr");
            if (hit)
                check_equal(mem_req.addr, model_mapper_addr(addr), "mem_req.addr");
            check_equal(ext_bus.mreq_n, is_io || internal, "external mreq_n");
            check_equal(ext_bus.iorq_n, !is_io || internal, "external iorq_n");
            // slot-bus strobe follows ISO_DELAY clocks late, never for internal accesses
            check_equal(ext_bus.rd_n, internal || is_wr || i < ISO_DELAY, "external rd_n");
            check_equal(ext_bus.wr_n, internal || !is_wr || i < ISO_DELAY, "external wr_n");
        end
        next_cycle();
        bus_in.rd_n = 1'b1;
        bus_in.wr_n = 1'b1;
        if (is_wr)
            model_write(is_io, addr, data);
        next_cycle();
        bus_in.mreq_n = 1'b1;
        bus_in.iorq_n = 1'b1;
        next_cycle();
    endtask

    task automatic check_demux();
        logic [15:0] addr;
        int          high_cnt;
        int          low_cnt;
        int          waited;
        logic        done;
        addr = 16'(rand_bits(16));
        high_cnt = 0;
        low_cnt  = 0;
        waited   = 0;
        done     = 1'b0;
        bus_in.addr = addr;
        next_cycle();
        update_addr = 1'b1;
        next_cycle();
        update_addr = 1'b0;
        while (!done && waited < WAIT_LIMIT) begin
            @(negedge clk_108m);
            waited++;
            if (ext_bus.msel == 2'b10) begin
                high_cnt++;
                check_equal(ext_bus.mp, addr[15:8], "mp during high select");
            end else if (ext_bus.msel == 2'b01) begin
                low_cnt++;
                check_equal(ext_bus.mp, addr[7:0], "mp during low select");
            end
            done = (low_cnt > 0) && (ext_bus.msel == 2'b00);
        end
        if (!done) begin
            timeouts++;
            $display("timeout at %0t: address select strobes did not return to idle", $time);
        end
        check_equal(high_cnt, T_ON, "cycles with high select");
        check_equal(low_cnt, T_ON, "cycles with low select");
        next_cycle();
    endtask

    task automatic check_isolation();
        logic [7:0] port;
        int         waited;
        port = 8'(rand_bits(8));
        // keep clear of PPI A and the config block
        if (port[7:4] == 4'h4 || port == PPI_A_PORT)
            port = port ^ 8'h80;
        bus_in.addr   = {8'(rand_bits(8)), port};
        bus_in.iorq_n = 1'b0;
        ext_data      = 8'(rand_bits(8));
        next_cycle();
        bus_in.rd_n = 1'b0;
        waited = 0;
        @(negedge clk_108m);
        while (ext_bus.rd_n && waited < WAIT_LIMIT) begin
            @(negedge clk_108m);
            waited++;
        end
        if (ext_bus.rd_n) begin
            timeouts++;
            $display("timeout at %0t: external rd_n never went low", $time);
        end else begin
            check_equal(waited, ISO_DELAY, "isolation delay");
            check_equal(cpu_din, ext_data, "read data from slot bus");
        end
        next_cycle();
        bus_in.rd_n = 1'b1;
        @(negedge clk_108m);
        check_equal(ext_bus.rd_n, 1'b1, "external rd_n release");
        next_cycle();
        bus_in.iorq_n = 1'b1;
        next_cycle();
    endtask

    initial begin
        logic [7:0] data;
        logic [1:0] slot;
        lfsr_state   = 32'h4cbc;
        checks       = 0;
        value_errors = 0;
        timeouts     = 0;
        bus_in       = '1;
        bus_in.addr  = '0;
        bus_in.dout  = '0;
        update_addr  = 1'b0;
        ext_data     = 8'h00;
        mem_rdata    = 8'h00;
        bus_reset_n  = 1'b0;
        model_reset();
        repeat (8) @(posedge clk_108m);
        #10;
        bus_reset_n = 1'b1;
        next_cycle();

        // PPI port A write and readback
        repeat (4) begin
            data = 8'(rand_bits(8));
            run_cycle(1'b1, 1'b1, {8'(rand_bits(8)), PPI_A_PORT}, data);
            run_cycle(1'b1, 1'b0, {8'(rand_bits(8)), PPI_A_PORT}, 8'h00);
        end

        // ------------------------------------------------------------------
        // expanded slot register, then mapper pages and random accesses
        // ------------------------------------------------------------------
        for (int r = 0; r < 4; r++) begin
            // page 3 into slot 0 so FFFFh reaches the register
            run_cycle(1'b1, 1'b1, {8'h00, PPI_A_PORT}, 8'(rand_bits(6)));
            data = (r == 0) ? 8'hFF : 8'(rand_bits(8));
            run_cycle(1'b0, 1'b1, 16'hFFFF, data);
            run_cycle(1'b0, 1'b0, 16'hFFFF, 8'h00);
            for (int p = 0; p < 4; p++)
                run_cycle(1'b1, 1'b1, {8'h00, MAPPER_PORT_BASE | 8'(p)}, 8'(rand_bits(8)));
            data = (r == 0) ? 8'h00 : 8'(rand_bits(8));
            run_cycle(1'b1, 1'b1, {8'h00, PPI_A_PORT}, data);
            repeat (8)
                run_cycle(1'b0, 1'(rand_bits(1)), 16'(rand_bits(16)), 8'(rand_bits(8)));
        end

        // config: locked write, unlock, move the mapper slot
        run_cycle(1'b1, 1'b1, {8'h00, CONFIG1_PORT}, 8'(rand_bits(8)));
        run_cycle(1'b1, 1'b0, {8'h00, CONFIG1_PORT}, 8'h00);
        run_cycle(1'b1, 1'b1, {8'h00, CONFIG0_PORT}, 8'h48);
        run_cycle(1'b1, 1'b0, {8'h00, CONFIG0_PORT}, 8'h00);
        run_cycle(1'b1, 1'b0, 16'h0047, 8'h00);
        slot = 2'(rand_bits(2));
        if (slot == 2'd0)
            slot = 2'd1;
        run_cycle(1'b1, 1'b1, {8'h00, CONFIG1_PORT}, {2'b00, slot, 4'b0001});
        run_cycle(1'b1, 1'b0, {8'h00, CONFIG1_PORT}, 8'h00);
        run_cycle(1'b1, 1'b1, {8'h00, PPI_A_PORT}, {4{slot}});
        repeat (8)
            run_cycle(1'b0, 1'(rand_bits(1)), 16'(rand_bits(16)), 8'(rand_bits(8)));

        repeat (3) check_demux();
        repeat (3) check_isolation();

        $display("checks %0d, value errors %0d, timeouts %0d", checks, value_errors, timeouts);
        if (value_errors == 0 && timeouts == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- source/slot_bridge_top.sv
`default_nettype none

module slot_bridge_top
    import bridge_pkg::*;
(
    input  wire        clk_108m,
    input  wire        bus_reset_n,
    input  cpu_bus_t   bus_in,
    input  wire        update_addr,
    input  wire  [7:0] ext_data,
    input  wire  [7:0] mem_rdata,
    output ext_bus_t   ext_bus,
    output mem_req_t   mem_req,
    output logic [7:0] cpu_din
);

    slot_info_t slot_info;
    config1_u   config1;
    logic [7:0] ppi_a;
    logic [7:0] exp_slot3;
    logic [7:0] config_rdata;
    logic       config_rd_hit;
    logic       mapper_hit;
    logic       mreq_disable;
    logic       iorq_disable;

    bus_sequencer u_sequencer (
        .clk_108m     (clk_108m),
        .bus_reset_n  (bus_reset_n),
        .bus_in       (bus_in),
        .update_addr  (update_addr),
        .mreq_disable (mreq_disable),
        .iorq_disable (iorq_disable),
        .ext_bus      (ext_bus)
    );

    slot_select u_slot (
        .clk_108m    (clk_108m),
        .bus_reset_n (bus_reset_n),
        .bus_in      (bus_in),
        .slot_info   (slot_info),
        .ppi_a       (ppi_a),
        .exp_slot3   (exp_slot3)
    );

    memory_mapper u_mapper (
        .clk_108m    (clk_108m),
        .bus_reset_n (bus_reset_n),
        .bus_in      (bus_in),
        .slot_info   (slot_info),
        .config1     (config1),
        .mem_req     (mem_req),
        .mapper_hit  (mapper_hit)
    );

    config_regs u_config (
        .clk_108m      (clk_108m),
        .bus_reset_n   (bus_reset_n),
        .bus_in        (bus_in),
        .config1       (config1),
        .config_rd_hit (config_rd_hit),
        .config_rdata  (config_rdata)
    );

    read_data_mux u_rdmux (
        .bus_in        (bus_in),
        .slot_info     (slot_info),
        .ppi_a         (ppi_a),
        .exp_slot3     (exp_slot3),
        .mapper_hit    (mapper_hit),
        .config_rd_hit (config_rd_hit),
        .config_rdata  (config_rdata),
        .mem_rdata     (mem_rdata),
        .ext_data      (ext_data),
        .cpu_din       (cpu_din),
        .mreq_disable  (mreq_disable),
        .iorq_disable  (iorq_disable)
    );

endmodule

`default_nettype wire

//--- source/read_data_mux.sv
`default_nettype none

module read_data_mux
    import bridge_pkg::*;
(
    input  cpu_bus_t   bus_in,
    input  slot_info_t slot_info,
    input  wire  [7:0] ppi_a,
    input  wire  [7:0] exp_slot3,
    input  wire        mapper_hit,
    input  wire        config_rd_hit,
    input  wire  [7:0] config_rdata,
    input  wire  [7:0] mem_rdata,
    input  wire  [7:0] ext_data,
    output logic [7:0] cpu_din,
    output logic       mreq_disable,
    output logic       iorq_disable
);

    logic slot0_req;
    logic slot0_rd;
    logic ppi_a_rd;

    assign slot0_req = !bus_in.mreq_n && (!bus_in.rd_n || !bus_in.wr_n)
                       && slot_info.pri_onehot[0];
    assign slot0_rd  = slot0_req && !bus_in.rd_n;
    assign ppi_a_rd  = !bus_in.iorq_n && bus_in.m1_n && !bus_in.rd_n
                       && (bus_in.addr[7:0] == PPI_A_PORT);

    // first match wins
    always_comb begin
        if (mapper_hit && !bus_in.rd_n)
            cpu_din = mem_rdata;
        else if (slot0_rd && slot_info.ffff_hit)
            cpu_din = ~exp_slot3;
        else if (ppi_a_rd)
            cpu_din = ppi_a;
        else if (config_rd_hit)
            cpu_din = config_rdata;
        else if (slot0_rd)
            cpu_din = 8'hFF;
        else
            cpu_din = ext_data;
    end

    assign mreq_disable = slot0_req | mapper_hit;
    assign iorq_disable = ppi_a_rd;

endmodule

`default_nettype wire

//--- source/config_regs.sv
`default_nettype none

module config_regs
    import bridge_pkg::*;
(
    input  wire        clk_108m,
    input  wire        bus_reset_n,
    input  cpu_bus_t   bus_in,
    output config1_u   config1,
    output logic       config_rd_hit,
    output logic [7:0] config_rdata
);

    logic [7:0] config0;
    logic       io_wr;
    logic       unlocked;

    assign io_wr    = !bus_in.iorq_n && bus_in.m1_n && !bus_in.wr_n;
    assign unlocked = (config0 == CONFIG_UNLOCK);

    // ----------------------------------------------------------------------
    // config0 holds the inverted unlock code, config1 the feature bits
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_108m or negedge bus_reset_n) begin
        if (!bus_reset_n) begin
            config0     <= 8'h00;
            config1.raw <= CONFIG1_RESET;
        end else begin
            if (io_wr && bus_in.addr[7:0] == CONFIG0_PORT)
                config0 <= ~bus_in.dout;
            if (io_wr && unlocked && bus_in.addr[7:0] == CONFIG1_PORT)
                config1.raw <= bus_in.dout;
        end
    end

    // whole 40..4Fh block answers reads
    assign config_rd_hit = !bus_in.iorq_n && bus_in.m1_n && !bus_in.rd_n
                           && (bus_in.addr[7:4] == CONFIG0_PORT[7:4]);

    always_comb begin
        if (bus_in.addr[3:0] == CONFIG0_PORT[3:0])
            config_rdata = config0;
        else if (bus_in.addr[3:0] == CONFIG1_PORT[3:0])
            config_rdata = config1.raw;
        else
            config_rdata = 8'hFF;
    end

endmodule

`default_nettype wire

//--- source/memory_mapper.sv
`default_nettype none

module memory_mapper
    import bridge_pkg::*;
(
    input  wire        clk_108m,
    input  wire        bus_reset_n,
    input  cpu_bus_t   bus_in,
    input  slot_info_t slot_info,
    input  config1_u   config1,
    output mem_req_t   mem_req,
    output logic       mapper_hit
);

    logic [3:0][7:0] pages;
    logic            page_wr;
    logic            slot_match;

    assign page_wr = !bus_in.iorq_n && bus_in.m1_n && !bus_in.wr_n
                     && (bus_in.addr[7:2] == MAPPER_PORT_BASE[7:2]);

    always_ff @(posedge clk_108m or negedge bus_reset_n) begin
        if (!bus_reset_n)
            pages <= MAPPER_RESET_PAGES;
        else if (page_wr)
            pages[bus_in.addr[1:0]] <= bus_in.dout;
    end

    // in slot 0 the mapper sits in subslot 3, clear of the FFFFh register
    assign slot_match = config1.fields.mapper_en
                        && (slot_info.pri_slot == config1.fields.mapper_slot)
                        && ((config1.fields.mapper_slot != 2'b00)
                            || (slot_info.exp_onehot[3] && !slot_info.ffff_hit));

    always_comb begin
        mem_req.addr = {pages[bus_in.addr[15:14]], bus_in.addr[13:0]};
        // no reads during refresh
        mem_req.rd   = slot_match && !bus_in.mreq_n && !bus_in.rd_n && bus_in.rfsh_n;
        mem_req.wr   = slot_match && !bus_in.mreq_n && !bus_in.wr_n;
    end

    assign mapper_hit = mem_req.rd | mem_req.wr;

    a_rd_wr_exclusive: assert property (@(posedge clk_108m) disable iff (!bus_reset_n)
        !(mem_req.rd && mem_req.wr));

endmodule

`default_nettype wire

//--- source/slot_select.sv
`default_nettype none

module slot_select
    import bridge_pkg::*;
(
    input  wire        clk_108m,
    input  wire        bus_reset_n,
    input  cpu_bus_t   bus_in,
    output slot_info_t slot_info,
    output logic [7:0] ppi_a,
    output logic [7:0] exp_slot3
);

    logic [1:0] page;
    logic [1:0] exp_page_slot;
    logic       ffff_q;
    logic       ppi_a_wr;
    logic       exp_wr;

    assign page = bus_in.addr[15:14];

    assign ppi_a_wr = !bus_in.iorq_n && bus_in.m1_n && !bus_in.wr_n
                      && (bus_in.addr[7:0] == PPI_A_PORT);

    // FFFFh compare lags the address by one clock
    always_ff @(posedge clk_108m or negedge bus_reset_n) begin
        if (!bus_reset_n)
            ffff_q <= 1'b0;
        else
            ffff_q <= (bus_in.addr == 16'hFFFF);
    end

    assign exp_wr = !bus_in.mreq_n && !bus_in.wr_n && ffff_q
                    && slot_info.pri_onehot[0];

    always_ff @(posedge clk_108m or negedge bus_reset_n) begin
        if (!bus_reset_n) begin
            ppi_a     <= 8'h00;
            exp_slot3 <= 8'h00;
        end else begin
            if (ppi_a_wr)
                ppi_a <= bus_in.dout;
            if (exp_wr)
                exp_slot3 <= bus_in.dout;
        end
    end

    // two bits per page in both registers
    assign exp_page_slot = exp_slot3[page * 2 +: 2];

    always_comb begin
        slot_info.pri_slot   = ppi_a[page * 2 +: 2];
        slot_info.pri_onehot = 4'b0001 << slot_info.pri_slot;
        slot_info.exp_onehot = 4'b0001 << exp_page_slot;
        slot_info.ffff_hit   = ffff_q;
    end

endmodule

`default_nettype wire

//--- source/bus_sequencer.sv
`default_nettype none

module bus_sequencer
    import bridge_pkg::*;
(
    input  wire      clk_108m,
    input  wire      bus_reset_n,
    input  cpu_bus_t bus_in,
    input  wire      update_addr,
    input  wire      mreq_disable,
    input  wire      iorq_disable,
    output ext_bus_t ext_bus
);

    logic [1:0] demux_state;
    logic [3:0] demux_cnt;
    logic [1:0] msel_q;
    logic       low_byte_q;

    logic [1:0] iso_state;
    logic [2:0] iso_cnt;
    logic       ext_rd_n_q;
    logic       ext_wr_n_q;
    logic       strobe_disable;

    // ----------------------------------------------------------------------
    // address demux: high byte, prefetch gap, low byte
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_108m or negedge bus_reset_n) begin
        if (!bus_reset_n) begin
            demux_state <= DEMUX_IDLE;
            demux_cnt   <= 4'd0;
            msel_q      <= 2'b00;
            low_byte_q  <= 1'b0;
        end else begin
            case (demux_state)
                DEMUX_IDLE: begin
                    demux_cnt  <= 4'd0;
                    low_byte_q <= 1'b0;
                    msel_q     <= 2'b00;
                    if (update_addr) begin
                        // high select goes out with the high byte
                        msel_q      <= 2'b10;
                        demux_state <= DEMUX_LATCH;
                    end
                end
                DEMUX_LATCH: begin
                    demux_cnt <= demux_cnt + 4'd1;
                    if (demux_cnt == 4'(T_ON - 1))
                        msel_q <= 2'b00;
                    // mp switches halfway through the gap
                    if (demux_cnt == 4'(T_ON + T_PREFETCH - 1))
                        low_byte_q <= 1'b1;
                    if (demux_cnt == 4'(T_ON + 2 * T_PREFETCH - 1))
                        msel_q <= 2'b01;
                    if (demux_cnt == 4'(2 * T_ON + 2 * T_PREFETCH - 1)) begin
                        msel_q      <= 2'b00;
                        demux_state <= DEMUX_FINISH;
                    end
                end
                DEMUX_FINISH: begin
                    if (!update_addr)
                        demux_state <= DEMUX_IDLE;
                end
                default: demux_state <= DEMUX_IDLE;
            endcase
        end
    end

    // ----------------------------------------------------------------------
    // rd/wr isolation towards the slot bus
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_108m or negedge bus_reset_n) begin
        if (!bus_reset_n) begin
            iso_state  <= ISO_IDLE;
            iso_cnt    <= 3'd0;
            ext_rd_n_q <= 1'b1;
            ext_wr_n_q <= 1'b1;
        end else begin
            case (iso_state)
                ISO_IDLE: begin
                    ext_rd_n_q <= 1'b1;
                    ext_wr_n_q <= 1'b1;
                    iso_cnt    <= 3'd1;
                    if (!bus_in.rd_n || !bus_in.wr_n)
                        iso_state <= ISO_ACTIVE;
                end
                ISO_ACTIVE: begin
                    iso_cnt <= iso_cnt + 3'd1;
                    if (iso_cnt == 3'(ISO_DELAY - 1)) begin
                        ext_rd_n_q <= bus_in.rd_n;
                        ext_wr_n_q <= bus_in.wr_n;
                        iso_state  <= ISO_WAIT;
                    end
                end
                ISO_WAIT: begin
                    if (bus_in.rd_n && bus_in.wr_n)
                        iso_state <= ISO_IDLE;
                end
                default: iso_state <= ISO_IDLE;
            endcase
        end
    end

    assign strobe_disable = mreq_disable | iorq_disable;

    // release follows the cpu strobe with no delay
    always_comb begin
        ext_bus.msel   = msel_q;
        ext_bus.mp     = low_byte_q ? bus_in.addr[7:0] : bus_in.addr[15:8];
        ext_bus.mreq_n = bus_in.mreq_n | mreq_disable;
        ext_bus.iorq_n = bus_in.iorq_n | iorq_disable;
        ext_bus.rd_n   = bus_in.rd_n | ext_rd_n_q | strobe_disable;
        ext_bus.wr_n   = bus_in.wr_n | ext_wr_n_q | strobe_disable;
    end

    // low select only after the full prefetch gap
    a_msel_gap: assert property (@(posedge clk_108m) disable iff (!bus_reset_n)
        $rose(ext_bus.msel[0]) |-> $past(ext_bus.msel, 2 * T_PREFETCH + 1) == 2'b10);

    // slot-bus rd_n only low after ISO_DELAY clocks of cpu rd_n
    a_rd_delayed: assert property (@(posedge clk_108m) disable iff (!bus_reset_n)
        !ext_bus.rd_n |-> $past(!bus_in.rd_n, ISO_DELAY));

endmodule

`default_nettype wire

//--- source/bridge_pkg.sv
`default_nettype none

package bridge_pkg;

    // ----------------------------------------------------------------------
    // I/O port map
    // ----------------------------------------------------------------------
    localparam logic [7:0] PPI_A_PORT       = 8'hA8;
    localparam logic [7:0] CONFIG0_PORT     = 8'h40;
    localparam logic [7:0] CONFIG1_PORT     = 8'h41;
    // only bits 7..2 are compared, so FC..FF
    localparam logic [7:0] MAPPER_PORT_BASE = 8'hFC;

    localparam logic [7:0] CONFIG_UNLOCK    = 8'hB7;
    localparam logic [7:0] CONFIG1_RESET    = 8'h0B;

    // page 0 gets segment 3, page 3 gets segment 0
    localparam logic [3:0][7:0] MAPPER_RESET_PAGES = {8'd0, 8'd1, 8'd2, 8'd3};

    // clk_108m cycles
    localparam int unsigned T_ON       = 3;
    localparam int unsigned T_PREFETCH = 1;
    localparam int unsigned ISO_DELAY  = 3;

    // demux sequencer states
    localparam logic [1:0] DEMUX_IDLE   = 2'd0;
    localparam logic [1:0] DEMUX_LATCH  = 2'd1;
    localparam logic [1:0] DEMUX_FINISH = 2'd3;

    // strobe isolation states
    localparam logic [1:0] ISO_IDLE   = 2'd0;
    localparam logic [1:0] ISO_ACTIVE = 2'd1;
    localparam logic [1:0] ISO_WAIT   = 2'd2;

    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  dout;
        logic        mreq_n;
        logic        iorq_n;
        logic        rd_n;
        logic        wr_n;
        logic        m1_n;
        logic        rfsh_n;
    } cpu_bus_t;

    typedef struct packed {
        logic [1:0] msel;
        logic [7:0] mp;
        logic       mreq_n;
        logic       iorq_n;
        logic       rd_n;
        logic       wr_n;
    } ext_bus_t;

    typedef struct packed {
        logic [21:0] addr;
        logic        rd;
        logic        wr;
    } mem_req_t;

    typedef struct packed {
        logic [1:0] pri_slot;
        logic [3:0] pri_onehot;
        logic [3:0] exp_onehot;
        logic       ffff_hit;
    } slot_info_t;

    // config1 is read back raw, the mapper decodes the fields
    typedef union packed {
        logic [7:0] raw;
        struct packed {
            logic [1:0] megaram_slot;
            logic [1:0] mapper_slot;
            logic       scanlines;
            logic       ghost_scc;
            logic       megaram_en;
            logic       mapper_en;
        } fields;
    } config1_u;

endpackage

`default_nettype wire
